// File: fc_consts.svh
`ifndef FC_CONSTS_SVH
`define FC_CONSTS_SVH

// receiver target, unsigned stick value
`define FC_REC_WIDTH 8
// rates and angles, two's complement q12.4
`define FC_RATE_WIDTH 16
// rate error times gain, 17 x 16 bits
`define FC_PROD_WIDTH 33
// angle scaling headroom
`define FC_SCALE_WIDTH 20
// four-term mixer sums
`define FC_MIX_WIDTH 19
// gain register address
`define FC_CFG_ADDR_WIDTH 2

// stick center, twice the target lands here
`define FC_REC_OFFSET 16'sd250
// angle stage scale, then arithmetic shift
`define FC_ANGLE_SCALE 5'sd8
`define FC_ANGLE_SHIFT 4
// q12.4 gain alignment
`define FC_GAIN_SHIFT 4

// angle stage limits
`define FC_THROTTLE_MAX 60
`define FC_AXIS_LIMIT 25
// rate stage saturation
`define FC_CORR_LIMIT 40
// motor ceiling, floor is zero
`define FC_MOTOR_MAX 100

// gain of one in q12.4
`define FC_KP_YAW_RST 16'd16
`define FC_KP_PITCH_RST 16'd16
`define FC_KP_ROLL_RST 16'd16

`endif

// File: fc_types_pkg.sv
`include "fc_consts.svh"

package fc_types_pkg;

	// receiver targets, one byte per stick
	typedef struct packed {
		logic [`FC_REC_WIDTH-1:0] throttle;
		logic [`FC_REC_WIDTH-1:0] yaw;
		logic [`FC_REC_WIDTH-1:0] pitch;
		logic [`FC_REC_WIDTH-1:0] roll;
	} setpoint_t;

	// imu angles
	typedef struct packed {
		logic [`FC_RATE_WIDTH-1:0] pitch;
		logic [`FC_RATE_WIDTH-1:0] roll;
	} attitude_t;

	// gyro rates
	typedef struct packed {
		logic [`FC_RATE_WIDTH-1:0] yaw;
		logic [`FC_RATE_WIDTH-1:0] pitch;
		logic [`FC_RATE_WIDTH-1:0] roll;
	} gyro_t;

	// rate targets and rate corrections share this
	typedef struct packed {
		logic [`FC_RATE_WIDTH-1:0] throttle;
		logic [`FC_RATE_WIDTH-1:0] yaw;
		logic [`FC_RATE_WIDTH-1:0] pitch;
		logic [`FC_RATE_WIDTH-1:0] roll;
	} rate_cmd_t;

	// mapped angle errors before scaling
	typedef struct packed {
		logic [`FC_RATE_WIDTH-1:0] pitch;
		logic [`FC_RATE_WIDTH-1:0] roll;
	} angle_err_t;

	// x-frame motor commands
	typedef struct packed {
		logic [`FC_RATE_WIDTH-1:0] front_left;
		logic [`FC_RATE_WIDTH-1:0] front_right;
		logic [`FC_RATE_WIDTH-1:0] rear_left;
		logic [`FC_RATE_WIDTH-1:0] rear_right;
	} motor_cmd_t;

endpackage

// File: fc_ctrl_pkg.sv
`include "fc_consts.svh"

package fc_ctrl_pkg;

	// angle controller fsm
	typedef enum logic [2:0] {
		as_waiting,
		as_mapping,
		as_scaling,
		as_limiting,
		as_complete
	} angle_state_e;

	// rate controller fsm
	typedef enum logic [2:0] {
		rs_idle,
		rs_error,
		rs_scale,
		rs_limit,
		rs_done
	} rate_state_e;

	// mixer fsm
	typedef enum logic [1:0] {
		ms_idle,
		ms_mix,
		ms_clamp,
		ms_done
	} mix_state_e;

	// gain register map, address 3 unused
	typedef enum logic [`FC_CFG_ADDR_WIDTH-1:0] {
		reg_kp_yaw   = 2'd0,
		reg_kp_pitch = 2'd1,
		reg_kp_roll  = 2'd2
	} cfg_reg_e;

	// proportional gains, q12.4
	typedef struct packed {
		logic [`FC_RATE_WIDTH-1:0] kp_yaw;
		logic [`FC_RATE_WIDTH-1:0] kp_pitch;
		logic [`FC_RATE_WIDTH-1:0] kp_roll;
	} gain_cfg_t;

endpackage

// File: angle_controller.sv
`timescale 1ns/1ps
`include "fc_consts.svh"

module angle_controller (
	input  logic                     us_clk,
	input  logic                     resetn,
	input  logic                     start_signal,
	input  logic                     frame_busy,
	input  fc_types_pkg::setpoint_t  targets,
	input  fc_types_pkg::attitude_t  attitude,
	output fc_types_pkg::rate_cmd_t  rate_targets,
	output fc_types_pkg::angle_err_t angle_err,
	output logic                     complete_signal,
	output logic                     active_signal
);
	import fc_types_pkg::*;
	import fc_ctrl_pkg::*;

	angle_state_e state, next_state;
	logic start_q;

	// inputs held for the whole frame
	setpoint_t tgt_q;
	attitude_t att_q;

	// stage registers
	logic [`FC_RATE_WIDTH-1:0] mapped_throttle;
	logic signed [`FC_RATE_WIDTH-1:0] mapped_yaw, mapped_pitch, mapped_roll;
	logic signed [`FC_SCALE_WIDTH-1:0] scaled_yaw, scaled_pitch, scaled_roll;

	// symmetric clamp to the axis limit
	function automatic logic [`FC_RATE_WIDTH-1:0] limit_axis(
		input logic signed [`FC_SCALE_WIDTH-1:0] value
	);
		if (value > `FC_AXIS_LIMIT)
			return `FC_RATE_WIDTH'(`FC_AXIS_LIMIT);
		else if (value < -`FC_AXIS_LIMIT)
			return `FC_RATE_WIDTH'(-`FC_AXIS_LIMIT);
		else
			return value[`FC_RATE_WIDTH-1:0];
	endfunction

	// start only counts while waiting and no frame in flight
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			start_q <= 1'b0;
		else if (state == as_waiting)
			start_q <= start_signal & ~frame_busy;
		else
			start_q <= 1'b0;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= as_waiting;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			as_waiting:  next_state = start_q ? as_mapping : as_waiting;
			as_mapping:  next_state = as_scaling;
			as_scaling:  next_state = as_limiting;
			as_limiting: next_state = as_complete;
			default:     next_state = as_waiting;
		endcase
	end

	// grab sticks and attitude as the frame opens
	always_ff @(posedge us_clk) begin
		if (state == as_waiting && start_q) begin
			tgt_q <= targets;
			att_q <= attitude;
		end
	end

	always_ff @(posedge us_clk) begin
		case (state)
			as_mapping: begin
				// throttle 0..250 -> times 4
				mapped_throttle <= {{(`FC_RATE_WIDTH-`FC_REC_WIDTH-2){1'b0}},
					tgt_q.throttle, 2'b00};
				// axes centered on the stick midpoint
				mapped_yaw <= $signed({1'b0, tgt_q.yaw, 1'b0}) - `FC_REC_OFFSET;
				// imu roll sign is flipped, so add it
				mapped_roll <= $signed({1'b0, tgt_q.roll, 1'b0}) - `FC_REC_OFFSET
					+ $signed(att_q.roll);
				mapped_pitch <= $signed({1'b0, tgt_q.pitch, 1'b0}) - `FC_REC_OFFSET
					- $signed(att_q.pitch);
			end
			as_scaling: begin
				// times 8 then back by 4, net half
				scaled_yaw <= (mapped_yaw * `FC_ANGLE_SCALE) >>> `FC_ANGLE_SHIFT;
				scaled_pitch <= (mapped_pitch * `FC_ANGLE_SCALE) >>> `FC_ANGLE_SHIFT;
				scaled_roll <= (mapped_roll * `FC_ANGLE_SCALE) >>> `FC_ANGLE_SHIFT;
			end
			default: begin
			end
		endcase
	end

	// outputs, held until the next limiting stage
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			rate_targets <= '0;
			angle_err <= '0;
			complete_signal <= 1'b0;
			active_signal <= 1'b0;
		end else begin
			// active covers mapping through limiting
			active_signal <= (next_state == as_mapping) || (next_state == as_scaling)
				|| (next_state == as_limiting);
			complete_signal <= (state == as_complete);
			if (state == as_limiting) begin
				// throttle floor is zero by construction
				if (mapped_throttle > `FC_THROTTLE_MAX)
					rate_targets.throttle <= `FC_RATE_WIDTH'(`FC_THROTTLE_MAX);
				else
					rate_targets.throttle <= mapped_throttle;
				rate_targets.yaw <= limit_axis(scaled_yaw);
				rate_targets.pitch <= limit_axis(scaled_pitch);
				rate_targets.roll <= limit_axis(scaled_roll);
				angle_err.pitch <= mapped_pitch;
				angle_err.roll <= mapped_roll;
			end
		end
	end

endmodule

// File: rate_controller.sv
`timescale 1ns/1ps
`include "fc_consts.svh"

module rate_controller (
	input  logic                    us_clk,
	input  logic                    resetn,
	input  logic                    start_signal,
	input  fc_types_pkg::rate_cmd_t rate_targets,
	input  fc_types_pkg::gyro_t     gyro,
	input  fc_ctrl_pkg::gain_cfg_t  gains,
	output fc_types_pkg::rate_cmd_t corrections,
	output logic                    complete_signal
);
	import fc_types_pkg::*;
	import fc_ctrl_pkg::*;

	rate_state_e state, next_state;

	// per-frame snapshot
	rate_cmd_t tgt_q;
	gyro_t gyro_q;
	gain_cfg_t gain_q;

	// one extra bit for the difference
	logic signed [`FC_RATE_WIDTH:0] err_yaw, err_pitch, err_roll;
	logic signed [`FC_PROD_WIDTH-1:0] prod_yaw, prod_pitch, prod_roll;

	// saturate to +/- corr limit
	function automatic logic [`FC_RATE_WIDTH-1:0] sat_corr(
		input logic signed [`FC_PROD_WIDTH-1:0] value
	);
		if (value > `FC_CORR_LIMIT)
			return `FC_RATE_WIDTH'(`FC_CORR_LIMIT);
		else if (value < -`FC_CORR_LIMIT)
			return `FC_RATE_WIDTH'(-`FC_CORR_LIMIT);
		else
			return value[`FC_RATE_WIDTH-1:0];
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= rs_idle;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			rs_idle:  next_state = start_signal ? rs_error : rs_idle;
			rs_error: next_state = rs_scale;
			rs_scale: next_state = rs_limit;
			rs_limit: next_state = rs_done;
			default:  next_state = rs_idle;
		endcase
	end

	always_ff @(posedge us_clk) begin
		case (state)
			rs_idle: begin
				// gyro and gains sampled on the start edge
				if (start_signal) begin
					tgt_q <= rate_targets;
					gyro_q <= gyro;
					gain_q <= gains;
				end
			end
			rs_error: begin
				err_yaw <= $signed(tgt_q.yaw) - $signed(gyro_q.yaw);
				err_pitch <= $signed(tgt_q.pitch) - $signed(gyro_q.pitch);
				err_roll <= $signed(tgt_q.roll) - $signed(gyro_q.roll);
			end
			rs_scale: begin
				// q12.4 times q12.4, drop 4 fraction bits
				prod_yaw <= (err_yaw * $signed(gain_q.kp_yaw)) >>> `FC_GAIN_SHIFT;
				prod_pitch <= (err_pitch * $signed(gain_q.kp_pitch)) >>> `FC_GAIN_SHIFT;
				prod_roll <= (err_roll * $signed(gain_q.kp_roll)) >>> `FC_GAIN_SHIFT;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			corrections <= '0;
		end else if (state == rs_limit) begin
			// throttle rides along untouched
			corrections.throttle <= tgt_q.throttle;
			corrections.yaw <= sat_corr(prod_yaw);
			corrections.pitch <= sat_corr(prod_pitch);
			corrections.roll <= sat_corr(prod_roll);
		end
	end

	// one cycle in done
	assign complete_signal = (state == rs_done);

endmodule

// File: gain_regs.sv
`timescale 1ns/1ps
`include "fc_consts.svh"

module gain_regs (
	input  logic                      us_clk,
	input  logic                      resetn,
	input  logic                      cfg_wr,
	input  fc_ctrl_pkg::cfg_reg_e     cfg_addr,
	input  logic [`FC_RATE_WIDTH-1:0] cfg_wdata,
	output fc_ctrl_pkg::gain_cfg_t    gains
);
	import fc_ctrl_pkg::*;

	// gains come up at unity
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			gains.kp_yaw <= `FC_KP_YAW_RST;
			gains.kp_pitch <= `FC_KP_PITCH_RST;
			gains.kp_roll <= `FC_KP_ROLL_RST;
		end else if (cfg_wr) begin
			// write lands on the strobe edge
			case (cfg_addr)
				reg_kp_yaw:   gains.kp_yaw <= cfg_wdata;
				reg_kp_pitch: gains.kp_pitch <= cfg_wdata;
				reg_kp_roll:  gains.kp_roll <= cfg_wdata;
				// spare address, write dropped
				default: begin
				end
			endcase
		end
	end

endmodule

// File: motor_mixer.sv
`timescale 1ns/1ps
`include "fc_consts.svh"

module motor_mixer (
	input  logic                     us_clk,
	input  logic                     resetn,
	input  logic                     start_signal,
	input  logic                     frame_active,
	input  fc_types_pkg::rate_cmd_t  corrections,
	output fc_types_pkg::motor_cmd_t motors,
	output logic                     complete_signal,
	output logic                     busy
);
	import fc_ctrl_pkg::*;

	mix_state_e state, next_state;
	logic busy_q;

	// raw x-frame sums, wide and signed
	logic signed [`FC_MIX_WIDTH-1:0] sum_fl, sum_fr, sum_rl, sum_rr;

	// clamp into 0..motor max
	function automatic logic [`FC_RATE_WIDTH-1:0] clamp_motor(
		input logic signed [`FC_MIX_WIDTH-1:0] value
	);
		if (value < 0)
			return '0;
		else if (value > `FC_MOTOR_MAX)
			return `FC_RATE_WIDTH'(`FC_MOTOR_MAX);
		else
			return value[`FC_RATE_WIDTH-1:0];
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= ms_idle;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			ms_idle:  next_state = start_signal ? ms_mix : ms_idle;
			ms_mix:   next_state = ms_clamp;
			ms_clamp: next_state = ms_done;
			default:  next_state = ms_idle;
		endcase
	end

	// front pair gets +pitch, left pair gets +roll, ccw props get +yaw
	always_ff @(posedge us_clk) begin
		if (state == ms_mix) begin
			sum_fl <= $signed(corrections.throttle) + $signed(corrections.pitch)
				+ $signed(corrections.roll) - $signed(corrections.yaw);
			sum_fr <= $signed(corrections.throttle) + $signed(corrections.pitch)
				- $signed(corrections.roll) + $signed(corrections.yaw);
			sum_rl <= $signed(corrections.throttle) - $signed(corrections.pitch)
				+ $signed(corrections.roll) + $signed(corrections.yaw);
			sum_rr <= $signed(corrections.throttle) - $signed(corrections.pitch)
				- $signed(corrections.roll) - $signed(corrections.yaw);
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motors <= '0;
		end else if (state == ms_clamp) begin
			motors.front_left <= clamp_motor(sum_fl);
			motors.front_right <= clamp_motor(sum_fr);
			motors.rear_left <= clamp_motor(sum_rl);
			motors.rear_right <= clamp_motor(sum_rr);
		end
	end

	// frame busy, armed by the angle stage, dropped as the frame ends
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			busy_q <= 1'b0;
		else if (state == ms_clamp)
			busy_q <= 1'b0;
		else if (frame_active)
			busy_q <= 1'b1;
	end

	// active covers the edge before busy_q catches up
	assign busy = frame_active | busy_q;
	assign complete_signal = (state == ms_done);

endmodule

// File: flight_core.sv
`timescale 1ns/1ps
`include "fc_consts.svh"

module flight_core (
	input  logic                      us_clk,
	input  logic                      resetn,
	input  logic                      start_signal,
	input  fc_types_pkg::setpoint_t   targets,
	input  fc_types_pkg::attitude_t   attitude,
	input  fc_types_pkg::gyro_t       gyro,
	input  logic                      cfg_wr,
	input  fc_ctrl_pkg::cfg_reg_e     cfg_addr,
	input  logic [`FC_RATE_WIDTH-1:0] cfg_wdata,
	output fc_types_pkg::motor_cmd_t  motors,
	output fc_types_pkg::angle_err_t  angle_err,
	output logic                      frame_done,
	output logic                      busy
);
	import fc_types_pkg::*;
	import fc_ctrl_pkg::*;

	// angle -> rate
	rate_cmd_t rate_targets;
	logic angle_done;
	logic angle_active;
	// rate -> mixer
	rate_cmd_t corrections;
	logic rate_done;
	gain_cfg_t gains;

	angle_controller angle_controller_inst (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_signal    (start_signal),
		.frame_busy      (busy),
		.targets         (targets),
		.attitude        (attitude),
		.rate_targets    (rate_targets),
		.angle_err       (angle_err),
		.complete_signal (angle_done),
		.active_signal   (angle_active)
	);

	rate_controller rate_controller_inst (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_signal    (angle_done),
		.rate_targets    (rate_targets),
		.gyro            (gyro),
		.gains           (gains),
		.corrections     (corrections),
		.complete_signal (rate_done)
	);

	gain_regs gain_regs_inst (
		.us_clk    (us_clk),
		.resetn    (resetn),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.gains     (gains)
	);

	motor_mixer motor_mixer_inst (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_signal    (rate_done),
		.frame_active    (angle_active),
		.corrections     (corrections),
		.motors          (motors),
		.complete_signal (frame_done),
		.busy            (busy)
	);

endmodule

// File: flight_checker.sv
`timescale 1ns/1ps

module flight_checker (
	input  logic                     us_clk,
	input  logic                     resetn,
	input  logic                     start_signal,
	input  logic                     busy,
	input  logic                     frame_done,
	input  fc_types_pkg::motor_cmd_t motors,
	input  fc_types_pkg::angle_err_t angle_err,
	input  logic                     exp_push,
	input  logic [127:0]             exp_name,
	input  fc_types_pkg::motor_cmd_t exp_motors,
	input  fc_types_pkg::angle_err_t exp_err,
	output int                       frames_checked,
	output int                       value_errors,
	output int                       other_errors
);
	import fc_types_pkg::*;

	// rising edges from the start sample to frame_done
	localparam int FRAME_EDGES = 12;

	// one queued frame result
	typedef struct packed {
		logic [127:0] name;
		motor_cmd_t   motors;
		angle_err_t   err;
	} expect_t;

	expect_t expect_q[$];
	expect_t incoming;
	expect_t cur;
	logic armed = 1'b0;
	int edge_count = 0;
	int reset_edges = 0;
	int n_frames = 0;
	int n_value = 0;
	int n_other = 0;

	assign frames_checked = n_frames;
	assign value_errors = n_value;
	assign other_errors = n_other;

	task automatic compare_word(input logic [127:0] test_name, input string field,
		input logic [15:0] expected, input logic [15:0] actual);
		if (actual !== expected) begin
			n_value++;
			$display("ERR %0s %s expected %0d actual %0d", test_name, field,
				$signed(expected), $signed(actual));
		end
	endtask

	// all sampling on the rising edge, so values are the settled pre-edge ones
	always @(posedge us_clk) begin
		if (!resetn) begin
			armed = 1'b0;
			// registers are only known once a reset edge has gone by
			if (reset_edges > 0) begin
				if (busy !== 1'b0 || frame_done !== 1'b0) begin
					n_other++;
					$display("busy or frame_done not low during reset");
				end
				if (motors !== '0 || angle_err !== '0) begin
					n_other++;
					$display("motor or angle outputs not cleared by reset");
				end
			end
			reset_edges++;
		end else begin
			if (exp_push === 1'b1) begin
				incoming.name = exp_name;
				incoming.motors = exp_motors;
				incoming.err = exp_err;
				expect_q.push_back(incoming);
			end
			// frame timing, edge 0 is the accepted start
			if (armed) begin
				edge_count++;
				if (frame_done !== 1'b1 && edge_count >= 2 && busy !== 1'b1) begin
					n_other++;
					$display("busy low %0d edges into a frame", edge_count - 1);
				end
				if (frame_done === 1'b1) begin
					armed = 1'b0;
					if (edge_count - 1 != FRAME_EDGES) begin
						n_other++;
						$display("frame_done came %0d edges after start, not %0d",
							edge_count - 1, FRAME_EDGES);
					end
					if (busy !== 1'b0) begin
						n_other++;
						$display("busy still high while frame_done is high");
					end
				end
			end else if (start_signal === 1'b1 && busy === 1'b0) begin
				armed = 1'b1;
				edge_count = 0;
			end else if (frame_done === 1'b1) begin
				n_other++;
				$display("frame_done without an accepted start");
			end
			// result compare on the done pulse
			if (frame_done === 1'b1) begin
				if (expect_q.size() == 0) begin
					n_other++;
					$display("frame_done with no frame expected");
				end else begin
					cur = expect_q.pop_front();
					n_frames++;
					compare_word(cur.name, "front_left", cur.motors.front_left,
						motors.front_left);
					compare_word(cur.name, "front_right", cur.motors.front_right,
						motors.front_right);
					compare_word(cur.name, "rear_left", cur.motors.rear_left, motors.rear_left);
					compare_word(cur.name, "rear_right", cur.motors.rear_right,
						motors.rear_right);
					compare_word(cur.name, "err_pitch", cur.err.pitch, angle_err.pitch);
					compare_word(cur.name, "err_roll", cur.err.roll, angle_err.roll);
				end
			end
		end
	end

endmodule

// File: flight_core_tb.sv
`timescale 1ns/1ps
`include "fc_consts.svh"

module flight_core_tb;
	import fc_types_pkg::*;
	import fc_ctrl_pkg::*;

	localparam DATA_FILE = "flight_testdata.txt";

	logic us_clk;
	logic resetn;
	logic start_signal;
	setpoint_t targets;
	attitude_t attitude;
	gyro_t gyro;
	logic cfg_wr;
	cfg_reg_e cfg_addr;
	logic [`FC_RATE_WIDTH-1:0] cfg_wdata;
	motor_cmd_t motors;
	angle_err_t angle_err;
	logic frame_done;
	logic busy;

	// expected frame handed to the checker
	logic exp_push;
	logic [127:0] exp_name;
	motor_cmd_t exp_motors;
	angle_err_t exp_err;
	int frames_checked;
	int value_errors;
	int other_errors;

	int cycle_count = 0;
	int cycle_limit = 0;
	int tb_errors = 0;
	int frames_sent = 0;

	flight_core flight_core_inst (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.start_signal (start_signal),
		.targets      (targets),
		.attitude     (attitude),
		.gyro         (gyro),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.motors       (motors),
		.angle_err    (angle_err),
		.frame_done   (frame_done),
		.busy         (busy)
	);

	flight_checker frame_checker (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.start_signal   (start_signal),
		.busy           (busy),
		.frame_done     (frame_done),
		.motors         (motors),
		.angle_err      (angle_err),
		.exp_push       (exp_push),
		.exp_name       (exp_name),
		.exp_motors     (exp_motors),
		.exp_err        (exp_err),
		.frames_checked (frames_checked),
		.value_errors   (value_errors),
		.other_errors   (other_errors)
	);

	// 4 ns period
	initial begin
		us_clk = 1'b0;
		forever #2 us_clk = ~us_clk;
	end

	always @(posedge us_clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles, the run did not finish", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	// one-cycle write strobe
	task automatic write_gain(input int addr, input int data);
		@(posedge us_clk);
		cfg_wr <= 1'b1;
		cfg_addr <= cfg_reg_e'(addr[1:0]);
		cfg_wdata <= data[15:0];
		@(posedge us_clk);
		cfg_wr <= 1'b0;
	endtask

	task automatic run_frame(input logic [127:0] name, input setpoint_t sp,
		input attitude_t att, input gyro_t gy, input motor_cmd_t em, input angle_err_t ee);
		@(posedge us_clk);
		targets <= sp;
		attitude <= att;
		gyro <= gy;
		start_signal <= 1'b1;
		exp_push <= 1'b1;
		exp_name <= name;
		exp_motors <= em;
		exp_err <= ee;
		// edge 0, start sampled here
		@(posedge us_clk);
		start_signal <= 1'b0;
		exp_push <= 1'b0;
		// second start, seen at edge 8 while the angle fsm waits and busy is up
		repeat (7) @(posedge us_clk);
		start_signal <= 1'b1;
		@(posedge us_clk);
		start_signal <= 1'b0;
		while (frame_done !== 1'b1)
			@(posedge us_clk);
	endtask

	initial begin
		int fd;
		int code;
		int line_count;
		int a;
		int d;
		int v[15];
		logic [63:0] kind;
		logic [127:0] name;
		logic [8*256-1:0] line;
		logic done;
		setpoint_t sp;
		attitude_t att;
		gyro_t gy;
		motor_cmd_t em;
		angle_err_t ee;

		resetn = 1'b0;
		start_signal = 1'b0;
		targets = '0;
		attitude = '0;
		gyro = '0;
		cfg_wr = 1'b0;
		cfg_addr = reg_kp_yaw;
		cfg_wdata = '0;
		exp_push = 1'b0;
		exp_name = '0;
		exp_motors = '0;
		exp_err = '0;
		done = 1'b0;

		// first pass only counts lines for the cycle limit
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			tb_errors++;
			$display("cannot open %s", DATA_FILE);
			done = 1'b1;
		end else begin
			line_count = 0;
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0)
					line_count++;
			end
			$fclose(fd);
			cycle_limit = 20 * line_count + 100;
			fd = $fopen(DATA_FILE, "r");
		end

		repeat (5) @(posedge us_clk);
		resetn <= 1'b1;
		@(posedge us_clk);

		while (!done) begin
			code = $fscanf(fd, "%s", kind);
			if (code != 1) begin
				done = 1'b1;
			end else if (kind == "W") begin
				code = $fscanf(fd, "%d %d", a, d);
				if (code != 2) begin
					tb_errors++;
					$display("malformed write line in %s", DATA_FILE);
				end else begin
					write_gain(a, d);
				end
			end else if (kind == "F") begin
				code = $fscanf(fd, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
					v[11], v[12], v[13], v[14]);
				if (code != 16) begin
					tb_errors++;
					$display("malformed frame line in %s", DATA_FILE);
				end else begin
					sp.throttle = v[0][7:0];
					sp.yaw = v[1][7:0];
					sp.pitch = v[2][7:0];
					sp.roll = v[3][7:0];
					att.pitch = v[4][15:0];
					att.roll = v[5][15:0];
					gy.yaw = v[6][15:0];
					gy.pitch = v[7][15:0];
					gy.roll = v[8][15:0];
					em.front_left = v[9][15:0];
					em.front_right = v[10][15:0];
					em.rear_left = v[11][15:0];
					em.rear_right = v[12][15:0];
					ee.pitch = v[13][15:0];
					ee.roll = v[14][15:0];
					frames_sent++;
					run_frame(name, sp, att, gy, em, ee);
				end
			end else begin
				// comment line, drop the rest of it
				code = $fgets(line, fd);
			end
		end
		if (fd != 0)
			$fclose(fd);

		// room for a stray frame_done to show up
		repeat (20) @(posedge us_clk);
		if (frames_checked != frames_sent) begin
			tb_errors++;
			$display("%0d frames sent but %0d checked", frames_sent, frames_checked);
		end
		$display("frames %0d, value errors %0d, other errors %0d", frames_checked,
			value_errors, other_errors + tb_errors);
		if (value_errors == 0 && other_errors + tb_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: flight_testdata.txt
# W addr data, decimal, addr 0 kp_yaw 1 kp_pitch 2 kp_roll
# F name thr yaw pitch roll att_pitch att_roll gyro_yaw gyro_pitch gyro_roll fl fr rl rr err_pitch err_roll
F center_t10 10 125 125 125 0 0 0 0 0 40 40 40 40 0 0
F thr_edge 15 125 125 125 0 0 0 0 0 60 60 60 60 0 0
F center_t20 20 125 125 125 0 0 0 0 0 60 60 60 60 0 0
F sat_pitch_roll 15 125 250 0 0 0 0 -30 30 60 100 0 60 250 -250
F att_sign 10 125 130 120 4 3 0 0 0 39 47 33 41 6 -7
F att_neg_yaw 12 130 125 125 -9 -5 2 1 -1 46 56 46 44 9 -5
F att_big 5 125 125 125 100 -100 0 0 0 0 20 20 70 -100 -100
F clamp_low 0 0 0 0 0 0 0 0 0 0 0 0 75 -250 -250
F clamp_high 250 125 250 250 0 0 0 -15 -15 100 60 60 0 250 250
F gain_base 10 125 135 135 0 0 0 0 0 60 40 40 20 20 20
W 1 32
W 2 8
F gain_after 10 125 135 135 0 0 0 0 0 65 55 25 15 20 20
W 3 0
F gain_spare 10 125 135 135 0 0 0 0 0 65 55 25 15 20 20
W 0 48
F gain_yaw 10 130 135 135 0 0 0 0 0 50 70 40 0 20 20
F gain_neg 10 125 125 121 0 0 0 0 1 37 43 37 43 0 -8
F gyro_mix 10 125 125 125 0 0 4 -6 8 60 44 12 44 0 0
W 0 16
W 1 16
W 2 16
F gains_restored 10 125 125 125 0 0 4 -6 8 42 50 22 46 0 0

// File: files.f
+incdir+.
fc_types_pkg.sv
fc_ctrl_pkg.sv
angle_controller.sv
rate_controller.sv
gain_regs.sv
motor_mixer.sv
flight_core.sv
flight_checker.sv
flight_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f files.f --top-module flight_core_tb -o flight_sim
./obj_dir/flight_sim > sim.log 2>&1
cat sim.log
if grep -qx "all tests passed" sim.log; then
	exit 0
fi
exit 1
